// ==== hdl/uart_cfg.svh ====
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// clk cycles per baud tick
`define UART_TICK_DIV 4

// Baud ticks per serial bit, so one bit is 16 clk cycles
`define UART_TICKS_PER_BIT 4

// FIFO depth is 2**UART_FIFO_AW entries
`define UART_FIFO_AW 4

// Bus widths
`define UART_ADDR_W 16
`define UART_DATA_W 32

`endif

// ==== hdl/uart_reg_pkg.sv ====
`include "uart_cfg.svh"

package uart_reg_pkg;

   typedef logic [`UART_ADDR_W-1:0] reg_addr_t;
   typedef logic [`UART_DATA_W-1:0] reg_data_t;

   // Word offsets of the register map
   typedef enum logic [15:0] {
      REG_STATUS = 16'h0000,
      REG_INTENA = 16'h0004,
      REG_TXDATA = 16'h0008,
      REG_RXDATA = 16'h000C
   } reg_offset_e;

   // STATUS bit positions
   typedef enum logic [4:0] {
      ST_RX_EMPTY = 5'd0,
      ST_TX_FULL  = 5'd8,
      ST_TX_EMPTY = 5'd10
   } status_bit_e;

endpackage

// ==== hdl/uart_line_pkg.sv ====
package uart_line_pkg;

   // One character on the serial line
   typedef logic [7:0] uart_byte_t;

   typedef enum logic [2:0] {
      TX_IDLE  = 3'd0,
      TX_START = 3'd1,
      TX_DATA  = 3'd2,
      TX_STOP  = 3'd3,
      TX_GAP   = 3'd4
   } tx_state_e;

   // Receiver returns to idle straight from the stop sample
   typedef enum logic [1:0] {
      RX_IDLE  = 2'd0,
      RX_START = 2'd1,
      RX_DATA  = 2'd2,
      RX_STOP  = 2'd3
   } rx_state_e;

endpackage

// ==== hdl/uart_baud_tick.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_baud_tick (
   input  logic clk,
   input  logic RST_N,
   output logic tick
);

   localparam int DIV = `UART_TICK_DIV;
   localparam int CW  = $clog2(DIV);

   logic [CW-1:0] div_cnt;
   logic          wrap;

   assign wrap = (div_cnt == CW'(DIV - 1));

   // One-cycle enable per wrap of the divider
   always_ff @(posedge clk or negedge RST_N) begin
      if (!RST_N) begin
         div_cnt <= '0;
         tick    <= 1'b0;
      end else begin
         tick <= wrap;
         if (wrap) begin
            div_cnt <= '0;
         end else begin
            div_cnt <= div_cnt + CW'(1);
         end
      end
   end

endmodule

// ==== hdl/uart_fifo.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_fifo import uart_line_pkg::*; (
   input  logic       clk,
   input  logic       RST_N,
   input  logic       push,
   input  uart_byte_t push_data,
   output logic       full,
   input  logic       pop,
   output uart_byte_t head,
   output logic       empty
);

   localparam int AW    = `UART_FIFO_AW;
   localparam int DEPTH = 1 << AW;

   uart_byte_t  mem [DEPTH];
   logic [AW:0] wr_ptr;
   logic [AW:0] rd_ptr;
   logic        do_push;
   logic        do_pop;

   // Top pointer bit tells a full buffer from an empty one
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                  (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   // First word fall-through
   assign head = mem[rd_ptr[AW-1:0]];

   always_ff @(posedge clk or negedge RST_N) begin
      if (!RST_N) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + (AW+1)'(1);
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + (AW+1)'(1);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr[AW-1:0]] <= push_data;
      end
   end

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_tx import uart_line_pkg::*; (
   input  logic       clk,
   input  logic       RST_N,
   input  logic       tick,
   input  logic       fifo_empty,
   input  uart_byte_t fifo_head,
   output logic       fifo_pop,
   output logic       txd
);

   localparam int TPB  = `UART_TICKS_PER_BIT;
   localparam int TC_W = $clog2(TPB);

   tx_state_e       state;
   logic [TC_W-1:0] tick_cnt;
   logic [2:0]      bit_cnt;
   uart_byte_t      shift_q;
   logic            bit_end;

   // Frame starts on a tick, so each bit spans exactly TPB ticks
   assign fifo_pop = (state == TX_IDLE) && tick && !fifo_empty;
   assign bit_end  = tick && (tick_cnt == TC_W'(TPB - 1));

   always_ff @(posedge clk or negedge RST_N) begin
      if (!RST_N) begin
         tick_cnt <= '0;
      end else if (state == TX_IDLE || bit_end) begin
         tick_cnt <= '0;
      end else if (tick) begin
         tick_cnt <= tick_cnt + TC_W'(1);
      end
   end

   always_ff @(posedge clk or negedge RST_N) begin
      if (!RST_N) begin
         state   <= TX_IDLE;
         bit_cnt <= '0;
         txd     <= 1'b1;
      end else begin
         case (state)
            TX_IDLE: begin
               if (fifo_pop) begin
                  state <= TX_START;
                  txd   <= 1'b0;
               end
            end
            TX_START: begin
               if (bit_end) begin
                  state   <= TX_DATA;
                  bit_cnt <= '0;
                  txd     <= shift_q[0];
               end
            end
            TX_DATA: begin
               if (bit_end) begin
                  if (bit_cnt == 3'd7) begin
                     state <= TX_STOP;
                     txd   <= 1'b1;
                  end else begin
                     // LSB first, next bit sits one above the current one
                     bit_cnt <= bit_cnt + 3'd1;
                     txd     <= shift_q[1];
                  end
               end
            end
            TX_STOP: begin
               if (bit_end) begin
                  state <= TX_GAP;
               end
            end
            TX_GAP: begin
               if (bit_end) begin
                  state <= TX_IDLE;
               end
            end
            default: begin
               state <= TX_IDLE;
               txd   <= 1'b1;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (fifo_pop) begin
         shift_q <= fifo_head;
      end else if (state == TX_DATA && bit_end) begin
         shift_q <= shift_q >> 1;
      end
   end

endmodule

// ==== hdl/uart_rx.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_rx import uart_line_pkg::*; (
   input  logic       clk,
   input  logic       RST_N,
   input  logic       tick,
   input  logic       rxd,
   output logic       rx_push,
   output uart_byte_t rx_byte
);

   localparam int TPB  = `UART_TICKS_PER_BIT;
   localparam int HALF = TPB / 2;
   localparam int TC_W = $clog2(TPB);

   logic [1:0]      sync_q;
   logic            rxd_s;
   logic            rxd_prev;
   rx_state_e       state;
   logic [TC_W-1:0] tick_cnt;
   logic [TC_W-1:0] tick_lim;
   logic [2:0]      bit_cnt;
   uart_byte_t      shift_q;
   logic            start_edge;
   logic            sample;

   //////////////////////////////////////////////////////////////////////
   // Line synchronizer and start edge

   always_ff @(posedge clk or negedge RST_N) begin
      if (!RST_N) begin
         sync_q   <= 2'b11;
         rxd_prev <= 1'b1;
      end else begin
         sync_q   <= {sync_q[0], rxd};
         rxd_prev <= rxd_s;
      end
   end

   assign rxd_s      = sync_q[1];
   assign start_edge = (state == RX_IDLE) && rxd_prev && !rxd_s;

   //////////////////////////////////////////////////////////////////////
   // Mid-bit sampling

   // Half a bit to the start middle, then whole bits
   assign tick_lim = (state == RX_START) ? TC_W'(HALF - 1) : TC_W'(TPB - 1);
   assign sample   = (state != RX_IDLE) && tick && (tick_cnt == tick_lim);

   always_ff @(posedge clk or negedge RST_N) begin
      if (!RST_N) begin
         tick_cnt <= '0;
      end else if (start_edge || sample) begin
         tick_cnt <= '0;
      end else if (tick && state != RX_IDLE) begin
         tick_cnt <= tick_cnt + TC_W'(1);
      end
   end

   always_ff @(posedge clk or negedge RST_N) begin
      if (!RST_N) begin
         state   <= RX_IDLE;
         bit_cnt <= '0;
         rx_push <= 1'b0;
      end else begin
         rx_push <= 1'b0;
         case (state)
            RX_IDLE: begin
               if (start_edge) begin
                  state <= RX_START;
               end
            end
            RX_START: begin
               if (sample) begin
                  // Glitch if the line is already high again
                  state   <= rxd_s ? RX_IDLE : RX_DATA;
                  bit_cnt <= '0;
               end
            end
            RX_DATA: begin
               if (sample) begin
                  if (bit_cnt == 3'd7) begin
                     state <= RX_STOP;
                  end else begin
                     bit_cnt <= bit_cnt + 3'd1;
                  end
               end
            end
            RX_STOP: begin
               if (sample) begin
                  rx_push <= rxd_s;
                  state   <= RX_IDLE;
               end
            end
            default: begin
               state <= RX_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == RX_DATA && sample) begin
         shift_q <= {rxd_s, shift_q[7:1]};
      end
   end

   assign rx_byte = shift_q;

endmodule

// ==== hdl/uart_regs.sv ====
`timescale 1ns/1ps

module uart_regs import uart_reg_pkg::*, uart_line_pkg::*; (
   input  logic       clk,
   input  logic       RST_N,
   input  logic       req_valid,
   output logic       req_ready,
   input  logic       req_write,
   input  reg_addr_t  req_addr,
   input  reg_data_t  req_wdata,
   output logic       rsp_valid,
   input  logic       rsp_ready,
   output reg_data_t  rsp_rdata,
   output logic       tx_push,
   output uart_byte_t tx_byte,
   input  logic       tx_full,
   input  logic       tx_empty,
   output logic       rx_pop,
   input  uart_byte_t rx_head,
   input  logic       rx_empty,
   output logic       interrupt
);

   logic      accept;
   reg_addr_t word_addr;
   reg_data_t status_w;
   reg_data_t rd_word;
   logic      ena_tx;
   logic      ena_rx;

   //////////////////////////////////////////////////////////////////////
   // Handshake and decode

   // One transaction in flight
   assign req_ready = !rsp_valid;
   assign accept    = req_valid && req_ready;
   assign word_addr = req_addr & ~reg_addr_t'(3);

   assign tx_push = accept && req_write && (word_addr == REG_TXDATA);
   assign tx_byte = req_wdata[7:0];
   assign rx_pop  = accept && !req_write && (word_addr == REG_RXDATA) && !rx_empty;

   always_comb begin
      status_w              = '0;
      status_w[ST_RX_EMPTY] = rx_empty;
      status_w[ST_TX_FULL]  = tx_full;
      status_w[ST_TX_EMPTY] = tx_empty;
   end

   // Read word, zero for writes and unmapped offsets
   always_comb begin
      rd_word = '0;
      if (!req_write) begin
         case (word_addr)
            REG_STATUS: rd_word = status_w;
            REG_INTENA: rd_word = reg_data_t'({ena_tx, ena_rx});
            REG_RXDATA: rd_word = rx_empty ? '0 : reg_data_t'(rx_head);
            default:    rd_word = '0;
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Response and enables

   always_ff @(posedge clk or negedge RST_N) begin
      if (!RST_N) begin
         rsp_valid <= 1'b0;
         ena_tx    <= 1'b0;
         ena_rx    <= 1'b0;
      end else begin
         if (accept) begin
            rsp_valid <= 1'b1;
         end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
         end
         if (accept && req_write && (word_addr == REG_INTENA)) begin
            ena_tx <= req_wdata[1];
            ena_rx <= req_wdata[0];
         end
      end
   end

   // Held until the master takes it
   always_ff @(posedge clk) begin
      if (accept) begin
         rsp_rdata <= rd_word;
      end
   end

   assign interrupt = (ena_tx && tx_full) || (ena_rx && rx_empty);

endmodule

// ==== hdl/uart_top.sv ====
`timescale 1ns/1ps

module uart_top import uart_reg_pkg::*, uart_line_pkg::*; (
   input  logic      clk,
   input  logic      RST_N,
   input  logic      req_valid,
   output logic      req_ready,
   input  logic      req_write,
   input  reg_addr_t req_addr,
   input  reg_data_t req_wdata,
   output logic      rsp_valid,
   input  logic      rsp_ready,
   output reg_data_t rsp_rdata,
   output logic      interrupt,
   output logic      txd,
   input  logic      rxd
);

   logic       tick;
   logic       tx_push;
   uart_byte_t tx_byte;
   logic       tx_full;
   logic       tx_empty;
   uart_byte_t tx_head;
   logic       tx_pop;
   logic       rx_push;
   uart_byte_t rx_byte;
   logic       rx_pop;
   uart_byte_t rx_head;
   logic       rx_empty;

   //////////////////////////////////////////////////////////////////////
   // Bus side

   uart_regs regs_i (
      .clk       (clk),
      .RST_N     (RST_N),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req_write (req_write),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_rdata (rsp_rdata),
      .tx_push   (tx_push),
      .tx_byte   (tx_byte),
      .tx_full   (tx_full),
      .tx_empty  (tx_empty),
      .rx_pop    (rx_pop),
      .rx_head   (rx_head),
      .rx_empty  (rx_empty),
      .interrupt (interrupt)
   );

   uart_fifo tx_fifo_i (
      .clk       (clk),
      .RST_N     (RST_N),
      .push      (tx_push),
      .push_data (tx_byte),
      .full      (tx_full),
      .pop       (tx_pop),
      .head      (tx_head),
      .empty     (tx_empty)
   );

   // Receive overflow drops the byte inside the FIFO
   uart_fifo rx_fifo_i (
      .clk       (clk),
      .RST_N     (RST_N),
      .push      (rx_push),
      .push_data (rx_byte),
      .full      (),
      .pop       (rx_pop),
      .head      (rx_head),
      .empty     (rx_empty)
   );

   //////////////////////////////////////////////////////////////////////
   // Line side

   uart_baud_tick baud_i (
      .clk   (clk),
      .RST_N (RST_N),
      .tick  (tick)
   );

   uart_tx tx_i (
      .clk        (clk),
      .RST_N      (RST_N),
      .tick       (tick),
      .fifo_empty (tx_empty),
      .fifo_head  (tx_head),
      .fifo_pop   (tx_pop),
      .txd        (txd)
   );

   uart_rx rx_i (
      .clk     (clk),
      .RST_N   (RST_N),
      .tick    (tick),
      .rxd     (rxd),
      .rx_push (rx_push),
      .rx_byte (rx_byte)
   );

endmodule

// ==== bench/uart_checker.sv ====
`timescale 1ns/1ps

module uart_checker import uart_reg_pkg::*; (
   input  logic      clk,
   input  logic      RST_N,
   input  logic      req_ready,
   input  logic      rsp_valid,
   input  logic      rsp_ready,
   input  reg_data_t rsp_rdata,
   input  logic      txd
);

   // Response word held while the master stalls
   a_rsp_hold: assert property (
      @(posedge clk) disable iff (!RST_N)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata)
   ) else $error("response changed while rsp_ready was low");

   // One transaction in flight
   a_one_txn: assert property (
      @(posedge clk) disable iff (!RST_N)
      !(req_ready && rsp_valid)
   ) else $error("req_ready high while a response is pending");

   a_txd_reset: assert property (
      @(posedge clk) !RST_N |-> txd
   ) else $error("txd low during reset");

endmodule

bind uart_top uart_checker checker_i (
   .clk       (clk),
   .RST_N     (RST_N),
   .req_ready (req_ready),
   .rsp_valid (rsp_valid),
   .rsp_ready (rsp_ready),
   .rsp_rdata (rsp_rdata),
   .txd       (txd)
);

// ==== bench/uart_tb.sv ====
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_tb
   import uart_reg_pkg::*, uart_line_pkg::*;
();

   localparam int BIT_CYC    = `UART_TICK_DIV * `UART_TICKS_PER_BIT;
   localparam int POLL_LIMIT = 200;
   localparam int MARGIN     = 2000;

   typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_POLL, OP_IRQ, OP_FRAME} op_e;

   // One row of the operation table
   typedef struct packed {
      op_e       op;
      reg_addr_t addr;
      reg_data_t wdata;
      reg_data_t exp;
      int        bp;
   } row_t;

   logic      clk;
   logic      RST_N;
   logic      req_valid;
   logic      req_ready;
   logic      req_write;
   reg_addr_t req_addr;
   reg_data_t req_wdata;
   logic      rsp_valid;
   logic      rsp_ready;
   reg_data_t rsp_rdata;
   logic      interrupt;
   logic      txd;

   row_t   rows[$];
   integer seed;
   int     cycles = 0;
   int     cycle_limit = 0;

   // Serial loopback
   uart_top dut_i (
      .clk       (clk),
      .RST_N     (RST_N),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req_write (req_write),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_rdata (rsp_rdata),
      .interrupt (interrupt),
      .txd       (txd),
      .rxd       (txd)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycle_limit > 0 && cycles > cycle_limit) begin
         $display("Timeout: the run went past %0d cycles", cycle_limit);
         $display("Done: errors found");
         $fatal(1, "run did not finish in time");
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers

   task automatic compare(input string name, input reg_data_t got, input reg_data_t exp);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
         $display("Done: errors found");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   function automatic void add_row(input op_e op, input reg_addr_t addr,
                                   input reg_data_t wdata, input reg_data_t exp,
                                   input int bp);
      row_t r;
      r.op    = op;
      r.addr  = addr;
      r.wdata = wdata;
      r.exp   = exp;
      r.bp    = bp;
      rows.push_back(r);
   endfunction

   // Starts and ends 1 ns after a rising edge
   task automatic bus_access(input logic write, input reg_addr_t addr, input reg_data_t wdata,
                             input int bp, output reg_data_t rdata);
      req_valid = 1'b1;
      req_write = write;
      req_addr  = addr;
      req_wdata = wdata;
      do begin
         @(negedge clk);
      end while (!req_ready);
      @(posedge clk);
      #1;
      req_valid = 1'b0;
      if (bp > 0) begin
         // Stalled response with a second request waiting
         rsp_ready = 1'b0;
         req_valid = 1'b1;
         req_write = 1'b0;
         req_addr  = REG_STATUS;
         repeat (bp) begin
            @(negedge clk);
            compare("rsp_valid", 32'(rsp_valid), 32'd1);
            compare("req_ready", 32'(req_ready), 32'd0);
            @(posedge clk);
            #1;
         end
         req_valid = 1'b0;
         rsp_ready = 1'b1;
      end
      do begin
         @(negedge clk);
      end while (!rsp_valid);
      rdata = rsp_rdata;
      @(posedge clk);
      #1;
   endtask

   // Samples txd at falling edges from the start bit on
   task automatic watch_frame(input uart_byte_t b);
      int k;
      do begin
         @(negedge clk);
      end while (txd !== 1'b0);
      for (k = 1; k < BIT_CYC; k++) begin
         @(negedge clk);
         compare("txd", 32'(txd), 32'd0);
      end
      // Middle of data bit 0
      repeat (BIT_CYC / 2 + 1) @(negedge clk);
      for (k = 0; k < 8; k++) begin
         compare("txd", 32'(txd), 32'(b[k]));
         repeat (BIT_CYC) @(negedge clk);
      end
      compare("txd", 32'(txd), 32'd1);
   endtask

   task automatic run_row(input row_t r);
      reg_data_t rd;
      int        n;
      logic      cleared;
      case (r.op)
         OP_WRITE: begin
            bus_access(1'b1, r.addr, r.wdata, r.bp, rd);
            compare("rsp_rdata", rd, r.exp);
         end
         OP_READ: begin
            bus_access(1'b0, r.addr, '0, r.bp, rd);
            compare("rsp_rdata", rd, r.exp);
         end
         OP_POLL: begin
            cleared = 1'b0;
            n       = 0;
            while (!cleared && n < POLL_LIMIT) begin
               bus_access(1'b0, r.addr, '0, 0, rd);
               cleared = !rd[r.wdata[4:0]];
               n++;
            end
            if (!cleared) begin
               $display("Bit %0d at 0x%0h did not clear after %0d reads",
                        r.wdata, r.addr, POLL_LIMIT);
               $display("Done: errors found");
               $fatal(1, "poll limit reached");
            end
         end
         OP_IRQ: begin
            @(negedge clk);
            compare("interrupt", 32'(interrupt), r.exp);
            @(posedge clk);
            #1;
         end
         default: begin
            fork
               bus_access(1'b1, REG_TXDATA, r.wdata, 0, rd);
               watch_frame(uart_byte_t'(r.wdata));
            join
            compare("rsp_rdata", rd, r.exp);
            @(posedge clk);
            #1;
         end
      endcase
   endtask

   //////////////////////////////////////////////////////////////////////
   // Operation table and run

   initial begin
      uart_byte_t b[6];
      int         i;
      seed      = 25;
      RST_N     = 1'b1;
      req_valid = 1'b0;
      req_write = 1'b0;
      req_addr  = '0;
      req_wdata = '0;
      rsp_ready = 1'b1;
      for (i = 0; i < 6; i++) begin
         b[i] = uart_byte_t'($random(seed));
      end

      // Reset state and interrupt enables
      add_row(OP_READ,  REG_STATUS, 0, 32'h401, 0);
      add_row(OP_IRQ,   REG_STATUS, 0, 0, 0);
      add_row(OP_WRITE, REG_INTENA, 1, 0, 0);
      add_row(OP_READ,  REG_INTENA, 0, 1, 0);
      add_row(OP_IRQ,   REG_STATUS, 0, 1, 0);
      add_row(OP_WRITE, REG_INTENA, 0, 0, 0);
      add_row(OP_IRQ,   REG_STATUS, 0, 0, 0);

      // Single byte, then four back to back
      add_row(OP_WRITE, REG_TXDATA, 32'(b[0]), 0, 0);
      add_row(OP_POLL,  REG_STATUS, 32'(ST_RX_EMPTY), 0, 0);
      add_row(OP_READ,  REG_RXDATA, 0, 32'(b[0]), 0);
      add_row(OP_READ,  REG_STATUS, 0, 32'h401, 0);
      for (i = 1; i < 5; i++) begin
         add_row(OP_WRITE, REG_TXDATA, 32'(b[i]), 0, 0);
      end
      for (i = 1; i < 5; i++) begin
         add_row(OP_POLL, REG_STATUS, 32'(ST_RX_EMPTY), 0, 0);
         add_row(OP_READ, REG_RXDATA, 0, 32'(b[i]), 0);
      end
      add_row(OP_READ,  REG_STATUS, 0, 32'h401, 0);

      // Frame on the line, then stalled responses
      add_row(OP_FRAME, REG_TXDATA, 32'(b[5]), 0, 0);
      add_row(OP_POLL,  REG_STATUS, 32'(ST_RX_EMPTY), 0, 0);
      add_row(OP_READ,  REG_RXDATA, 0, 32'(b[5]), 5);
      add_row(OP_READ,  REG_STATUS, 0, 32'h401, 5);

      // Empty receive FIFO and an unmapped offset
      add_row(OP_READ,  REG_RXDATA, 0, 0, 0);
      add_row(OP_READ,  16'h0020, 0, 0, 0);
      add_row(OP_READ,  REG_INTENA, 0, 0, 0);

      cycle_limit = rows.size() * 12 * BIT_CYC + MARGIN;

      #1;
      RST_N = 1'b0;
      repeat (8) @(posedge clk);
      #1;
      RST_N = 1'b1;
      compare("txd", 32'(txd), 32'd1);

      for (i = 0; i < rows.size(); i++) begin
         run_row(rows[i]);
      end

      $display("Done: no errors");
      $finish;
   end

endmodule

// ==== tb.f ====
+incdir+hdl
hdl/uart_reg_pkg.sv
hdl/uart_line_pkg.sv
hdl/uart_baud_tick.sv
hdl/uart_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_regs.sv
hdl/uart_top.sv
bench/uart_checker.sv
bench/uart_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     := --timing --assert
TOP       := uart_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
